// File: verilog.f
+incdir+logic
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips.sv
testbench/mips_assert.sv
testbench/mips_tb.sv

// File: Bender.yml
package:
  name: mips

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_isa_pkg.sv
      - logic/mips_pipe_pkg.sv
      - logic/reg_file.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/hazard_unit.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/mips.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/mips_assert.sv
      - testbench/mips_tb.sv

// File: testbench/mips_tb.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mips_tb
  import mips_isa_pkg::*;
();

  logic     clk;
  logic     reset;
  word_t    imem_data;
  word_t    imem_addr;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_data;

  word_t    prog [64];
  string    prog_tag [64];
  int       prog_len;
  int       seed;
  reg_idx_t exp_rd [$];
  word_t    exp_data [$];
  string    exp_tag [$];
  int       matched;
  int       executed;
  int       limit;
  int       cycles;
  logic [15:0] imm_a, imm_b, imm_c, imm_d;

  mips i_mips (
    .clk(clk), .reset(reset), .imem_data(imem_data), .imem_addr(imem_addr),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  always #5 clk = ~clk;

  function automatic word_t rtype_word(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                       logic [4:0] sh);
    return {OP_SPECIAL, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t itype_word(opcode_e op, reg_idx_t rt, reg_idx_t rs,
                                       logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [15:0] random_imm();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  task automatic append_instr(word_t w, string tag);
    prog[prog_len]     = w;
    prog_tag[prog_len] = tag;
    prog_len++;
  endtask

  // past the program the core sees sll r0 which retires silently
  function automatic word_t fetch_word(word_t addr);
    if ($isunknown(addr) || (addr >> 2) >= prog_len) begin
      return '0;
    end
    return prog[addr >> 2];
  endfunction

  // sequential ISA model producing one entry per write to a nonzero register
  function automatic int run_reference();
    word_t       regs [`MIPS_REG_COUNT];
    word_t       dmem [`MIPS_DMEM_WORDS];
    word_t       pc, instr, a, b, res, simm, ea;
    logic [15:0] imm;
    reg_idx_t    dst;
    logic        wr;
    int          idx;
    int          steps;
    for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
      regs[i] = '0;
    end
    pc    = `MIPS_RESET_PC;
    steps = 0;
    while ((pc >> 2) < prog_len && steps < 1000) begin
      idx   = pc >> 2;
      instr = prog[idx];
      a     = regs[instr[25:21]];
      b     = regs[instr[20:16]];
      imm   = instr[15:0];
      simm  = {{16{imm[15]}}, imm};
      ea    = a + simm;
      dst   = instr[20:16];
      wr    = 1'b1;
      res   = '0;
      pc    = pc + 4;
      case (instr[31:26])
        OP_SPECIAL: begin
          dst = instr[15:11];
          case (instr[5:0])
            FN_SLL:  res = b << instr[10:6];
            FN_SRL:  res = b >> instr[10:6];
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: wr = 1'b0;
          endcase
        end
        OP_ADDIU: res = a + simm;
        OP_ANDI:  res = a & {16'h0000, imm};
        OP_ORI:   res = a | {16'h0000, imm};
        OP_LUI:   res = {imm, 16'h0000};
        OP_LW:    res = dmem[(ea >> 2) % `MIPS_DMEM_WORDS];
        OP_SW: begin
          wr = 1'b0;
          dmem[(ea >> 2) % `MIPS_DMEM_WORDS] = b;
        end
        OP_BEQ: begin
          wr = 1'b0;
          if (a == b) pc = pc + (simm << 2);
        end
        OP_BNE: begin
          wr = 1'b0;
          if (a != b) pc = pc + (simm << 2);
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != '0) begin
        regs[dst] = res;
        exp_rd.push_back(dst);
        exp_data.push_back(res);
        exp_tag.push_back(prog_tag[idx]);
      end
      steps++;
    end
    return steps;
  endfunction

  task automatic check_reg_idx(string name, reg_idx_t exp, reg_idx_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: destination expected r%0d actual r%0d", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "writeback destination mismatch");
    end
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: data expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "writeback data mismatch");
    end
  endtask

  always @(negedge clk) begin
    imem_data <= fetch_word(imem_addr);
  end

  // one expected entry per wb_valid in program order
  always @(negedge clk) begin
    if (wb_valid === 1'b1) begin
      if (matched >= exp_rd.size()) begin
        $display("writeback to r%0d arrived after the last expected write", wb_rd);
        $display("TEST FAIL");
        $fatal(1, "extra writeback");
      end else begin
        check_reg_idx($sformatf("%s #%0d", exp_tag[matched], matched), exp_rd[matched], wb_rd);
        check_word($sformatf("%s #%0d", exp_tag[matched], matched), exp_data[matched], wb_data);
        matched++;
      end
    end
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    imem_data = '0;
    matched   = 0;
    prog_len  = 0;
    cycles    = 0;
    seed      = 68814;
    imm_a     = random_imm();
    imm_b     = random_imm() | 16'h8000;
    imm_c     = random_imm() | 16'h8000;
    imm_d     = random_imm() | 16'h8000;

    append_instr(itype_word(OP_ADDIU, 1, 0, imm_a), "imm_ext");
    append_instr(itype_word(OP_ADDIU, 2, 0, imm_b), "imm_ext");
    append_instr(itype_word(OP_ANDI, 3, 2, imm_c), "imm_ext");
    append_instr(itype_word(OP_ORI, 4, 3, imm_d), "imm_ext");
    append_instr(itype_word(OP_LUI, 5, 0, imm_a), "imm_ext");
    append_instr(rtype_word(FN_ADDU, 6, 4, 5, 0), "rtype_fwd");
    append_instr(rtype_word(FN_SUBU, 7, 6, 2, 0), "rtype_fwd");
    append_instr(rtype_word(FN_AND, 8, 7, 6, 0), "rtype_fwd");
    append_instr(rtype_word(FN_OR, 9, 8, 3, 0), "rtype_fwd");
    append_instr(rtype_word(FN_XOR, 10, 9, 7, 0), "rtype_fwd");
    append_instr(rtype_word(FN_SLT, 11, 10, 2, 0), "rtype_fwd");
    append_instr(rtype_word(FN_SLT, 12, 2, 10, 0), "rtype_fwd");
    // the younger of two r28 writers feeds subu
    append_instr(rtype_word(FN_ADDU, 28, 1, 2, 0), "rtype_fwd");
    append_instr(rtype_word(FN_XOR, 28, 28, 4, 0), "rtype_fwd");
    append_instr(rtype_word(FN_SUBU, 31, 28, 5, 0), "rtype_fwd");
    append_instr(rtype_word(FN_SLL, 13, 0, 10, 7), "shift");
    append_instr(rtype_word(FN_SRL, 14, 0, 13, 3), "shift");
    append_instr(rtype_word(FN_SLL, 15, 0, 14, 31), "shift");
    append_instr(rtype_word(FN_SRL, 16, 0, 10, 31), "shift");
    append_instr(itype_word(OP_ORI, 17, 0, 16'h0040), "load_store");
    append_instr(itype_word(OP_SW, 10, 17, 16'h0000), "load_store");
    append_instr(itype_word(OP_SW, 13, 17, 16'h0004), "load_store");
    append_instr(itype_word(OP_LW, 18, 17, 16'h0000), "load_store");
    append_instr(rtype_word(FN_ADDU, 19, 18, 13, 0), "load_store");
    append_instr(itype_word(OP_LW, 20, 17, 16'h0004), "load_store");
    append_instr(itype_word(OP_SW, 20, 17, 16'h0008), "load_store");
    append_instr(itype_word(OP_LW, 21, 17, 16'h0008), "load_store");
    append_instr(rtype_word(FN_XOR, 22, 21, 18, 0), "load_store");
    // beq skips one when taken and falls through when not
    append_instr(itype_word(OP_BEQ, 10, 18, 16'h0001), "branch");
    append_instr(itype_word(OP_ADDIU, 23, 0, 16'h0001), "branch");
    append_instr(itype_word(OP_BNE, 10, 18, 16'h0001), "branch");
    append_instr(itype_word(OP_BEQ, 0, 17, 16'h0001), "branch");
    append_instr(itype_word(OP_ADDIU, 27, 0, 16'h0003), "branch");
    // four-pass countdown loop on bne
    append_instr(itype_word(OP_ADDIU, 24, 0, 16'h0004), "branch");
    append_instr(rtype_word(FN_ADDU, 25, 25, 24, 0), "branch");
    append_instr(itype_word(OP_ADDIU, 24, 24, 16'hffff), "branch");
    append_instr(itype_word(OP_BNE, 0, 24, 16'hfffd), "branch");
    append_instr(itype_word(OP_ADDIU, 26, 0, 16'h0007), "branch");
    append_instr(itype_word(OP_ADDIU, 0, 0, imm_b), "reg_zero");
    append_instr(rtype_word(FN_ADDU, 29, 0, 1, 0), "reg_zero");
    append_instr(itype_word(OP_LW, 0, 17, 16'h0000), "reg_zero");
    append_instr(rtype_word(FN_OR, 30, 0, 25, 0), "reg_zero");

    executed = run_reference();
    limit    = 3 * executed + 20;

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    while (matched < exp_rd.size() && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    // a few more cycles so a stray late write is caught
    repeat (8) @(posedge clk);

    if (matched == exp_rd.size()) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("writebacks stopped arriving: %0d of %0d seen within %0d cycles",
               matched, exp_rd.size(), limit);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

endmodule

// File: testbench/mips_assert.sv
`timescale 1ns/10ps

module mips_assert
  import mips_isa_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     stall,
  input logic     wb_valid,
  input reg_idx_t wb_rd,
  input word_t    imem_addr
);

  // r0 writes die in the memory stage
  wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_rd != '0)
    else $error("writeback port reported a write to r0");

  wb_quiet_after_reset: assert property (@(posedge clk)
    reset |=> !wb_valid)
    else $error("wb_valid high in the cycle after reset");

  pc_aligned: assert property (@(posedge clk) disable iff (reset)
    imem_addr[1:0] == 2'b00)
    else $error("imem_addr is not word aligned");

  // load-use hold keeps the pc
  pc_held_on_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(imem_addr))
    else $error("imem_addr moved during a stall");

endmodule

bind mips mips_assert u_mips_assert (
  .clk(clk), .reset(reset), .stall(stall), .wb_valid(wb_valid), .wb_rd(wb_rd),
  .imem_addr(imem_addr)
);

// File: logic/mips.sv
`timescale 1ns/10ps

module mips
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  word_t    imem_data,
  output word_t    imem_addr,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  // fetch to decode
  word_t    id_instr, id_pc_plus4;
  logic     id_valid;
  reg_idx_t id_rs, id_rt;

  // decode to execute
  reg_idx_t ex_rs, ex_rt, ex_rd;
  word_t    ex_a, ex_b, ex_imm, ex_target;
  logic [4:0] ex_shamt;
  alu_op_e  ex_alu_op;
  logic     ex_alu_src, ex_shift_src, ex_reg_write, ex_mem_read, ex_mem_write;
  logic     ex_branch_eq, ex_branch_ne;

  // execute to memory
  word_t    mem_result, mem_store;
  reg_idx_t mem_rd;
  logic     mem_reg_write, mem_mem_read, mem_mem_write;

  // hazard and redirect
  logic     stall, redirect, flush;
  word_t    branch_target;
  fwd_sel_e fwd_a, fwd_b;

  fetch_stage u_fetch (
    .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
    .branch_target(branch_target), .imem_data(imem_data), .imem_addr(imem_addr),
    .id_instr(id_instr), .id_pc_plus4(id_pc_plus4), .id_valid(id_valid)
  );

  decode_stage u_decode (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush),
    .id_instr(id_instr), .id_pc_plus4(id_pc_plus4), .id_valid(id_valid),
    .wb_write(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
    .id_rs(id_rs), .id_rt(id_rt), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
    .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm), .ex_target(ex_target),
    .ex_shamt(ex_shamt), .ex_alu_op(ex_alu_op),
    .ex_alu_src(ex_alu_src), .ex_shift_src(ex_shift_src), .ex_reg_write(ex_reg_write),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .ex_branch_eq(ex_branch_eq), .ex_branch_ne(ex_branch_ne)
  );

  hazard_unit u_hazard (
    .id_rs(id_rs), .id_rt(id_rt), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
    .ex_mem_read(ex_mem_read), .mem_rd(mem_rd), .wb_rd(wb_rd),
    .mem_reg_write(mem_reg_write), .wb_write(wb_valid),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  execute_stage u_execute (
    .clk(clk), .reset(reset),
    .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm), .ex_target(ex_target),
    .ex_shamt(ex_shamt), .ex_alu_op(ex_alu_op),
    .ex_alu_src(ex_alu_src), .ex_shift_src(ex_shift_src), .ex_reg_write(ex_reg_write),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .ex_branch_eq(ex_branch_eq), .ex_branch_ne(ex_branch_ne), .ex_rd(ex_rd),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(wb_data),
    .redirect(redirect), .flush(flush), .branch_target(branch_target),
    .mem_result(mem_result), .mem_store(mem_store), .mem_rd(mem_rd),
    .mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write)
  );

  memory_stage u_memory (
    .clk(clk), .reset(reset),
    .mem_result(mem_result), .mem_store(mem_store), .mem_rd(mem_rd),
    .mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
    .wb_write(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module memory_stage
  import mips_isa_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  word_t    mem_result,
  input  word_t    mem_store,
  input  reg_idx_t mem_rd,
  input  logic     mem_reg_write,
  input  logic     mem_mem_read,
  input  logic     mem_mem_write,
  output logic     wb_write,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  localparam int ADDR_W = $clog2(`MIPS_DMEM_WORDS);

  word_t             dmem [`MIPS_DMEM_WORDS];
  logic [ADDR_W-1:0] word_addr;
  word_t             load_data;

  // word index, byte offset bits ignored
  assign word_addr = mem_result[ADDR_W+1:2];
  assign load_data = dmem[word_addr];

  always_ff @(posedge clk) begin
    if (mem_mem_write) begin
      dmem[word_addr] <= mem_store;
    end
  end

  // r0 writes die here and never reach the port
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_write <= 1'b0;
    end else begin
      wb_write <= mem_reg_write && mem_rd != '0;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= mem_mem_read ? load_data : mem_result;
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  word_t      ex_a,
  input  word_t      ex_b,
  input  word_t      ex_imm,
  input  word_t      ex_target,
  input  logic [4:0] ex_shamt,
  input  alu_op_e    ex_alu_op,
  input  logic       ex_alu_src,
  input  logic       ex_shift_src,
  input  logic       ex_reg_write,
  input  logic       ex_mem_read,
  input  logic       ex_mem_write,
  input  logic       ex_branch_eq,
  input  logic       ex_branch_ne,
  input  reg_idx_t   ex_rd,
  input  fwd_sel_e   fwd_a,
  input  fwd_sel_e   fwd_b,
  input  word_t      wb_data,
  output logic       redirect,
  output logic       flush,
  output word_t      branch_target,
  output word_t      mem_result,
  output word_t      mem_store,
  output reg_idx_t   mem_rd,
  output logic       mem_reg_write,
  output logic       mem_mem_read,
  output logic       mem_mem_write
);

  word_t op_a, op_b, alu_a, alu_b, alu_y;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                    word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a, ex_a, mem_result, wb_data);
  assign op_b  = fwd_mux(fwd_b, ex_b, mem_result, wb_data);
  assign alu_a = ex_shift_src ? word_t'(ex_shamt) : op_a;
  assign alu_b = ex_alu_src ? ex_imm : op_b;

  always_comb begin
    case (ex_alu_op)
      ALU_ADD: alu_y = alu_a + alu_b;
      ALU_SUB: alu_y = alu_a - alu_b;
      ALU_AND: alu_y = alu_a & alu_b;
      ALU_OR:  alu_y = alu_a | alu_b;
      ALU_XOR: alu_y = alu_a ^ alu_b;
      ALU_SLT: alu_y = word_t'($signed(alu_a) < $signed(alu_b));
      ALU_SLL: alu_y = alu_b << alu_a[4:0];
      ALU_SRL: alu_y = alu_b >> alu_a[4:0];
      ALU_LUI: alu_y = alu_b << 16;
      default: alu_y = '0;
    endcase
  end

  // branch resolves here, the two younger slots are dropped
  assign redirect      = (ex_branch_eq && op_a == op_b) || (ex_branch_ne && op_a != op_b);
  assign flush         = redirect;
  assign branch_target = ex_target;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
    end
  end

  always_ff @(posedge clk) begin
    mem_result <= alu_y;
    mem_store  <= op_b;
    mem_rd     <= ex_rd;
  end

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  reg_idx_t id_rs,
  input  reg_idx_t id_rt,
  input  reg_idx_t ex_rs,
  input  reg_idx_t ex_rt,
  input  reg_idx_t ex_rd,
  input  logic     ex_mem_read,
  input  reg_idx_t mem_rd,
  input  reg_idx_t wb_rd,
  input  logic     mem_reg_write,
  input  logic     wb_write,
  output logic     stall,
  output fwd_sel_e fwd_a,
  output fwd_sel_e fwd_b
);

  // younger producer wins
  function automatic fwd_sel_e pick_src(reg_idx_t src, reg_idx_t m_rd, logic m_we,
                                        reg_idx_t w_rd, logic w_we);
    if (m_we && m_rd != '0 && m_rd == src) begin
      return FWD_MEM;
    end
    if (w_we && w_rd != '0 && w_rd == src) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  // load data is not ready until memory, hold one cycle
  assign stall = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs || ex_rd == id_rt);

  assign fwd_a = pick_src(ex_rs, mem_rd, mem_reg_write, wb_rd, wb_write);
  assign fwd_b = pick_src(ex_rt, mem_rd, mem_reg_write, wb_rd, wb_write);

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module decode_stage
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,
  input  logic       flush,
  input  word_t      id_instr,
  input  word_t      id_pc_plus4,
  input  logic       id_valid,
  input  logic       wb_write,
  input  reg_idx_t   wb_rd,
  input  word_t      wb_data,
  output reg_idx_t   id_rs,
  output reg_idx_t   id_rt,
  output reg_idx_t   ex_rs,
  output reg_idx_t   ex_rt,
  output reg_idx_t   ex_rd,
  output word_t      ex_a,
  output word_t      ex_b,
  output word_t      ex_imm,
  output word_t      ex_target,
  output logic [4:0] ex_shamt,
  output alu_op_e    ex_alu_op,
  output logic       ex_alu_src,
  output logic       ex_shift_src,
  output logic       ex_reg_write,
  output logic       ex_mem_read,
  output logic       ex_mem_write,
  output logic       ex_branch_eq,
  output logic       ex_branch_ne
);

  reg_idx_t    rs_f, rt_f, rd_f;
  logic [15:0] imm16;
  word_t       rs_data, rt_data, sext_imm;
  alu_op_e     alu_op;
  logic        alu_src, shift_src, reg_write, mem_read, mem_write;
  logic        branch_eq, branch_ne, sign_ext, use_rs, use_rt, dest_rt;

  assign rs_f     = id_instr[25:21];
  assign rt_f     = id_instr[20:16];
  assign rd_f     = id_instr[15:11];
  assign imm16    = id_instr[15:0];
  assign sext_imm = {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

  // unused sources show up as r0 so the hazard unit ignores them
  assign id_rs = use_rs ? rs_f : '0;
  assign id_rt = use_rt ? rt_f : '0;

  reg_file u_reg_file (
    .clk(clk), .reset(reset), .write(wb_write), .rd(wb_rd),
    .rs(rs_f), .rt(rt_f), .wdata(wb_data), .rs_data(rs_data), .rt_data(rt_data)
  );

  always_comb begin
    alu_op    = ALU_ADD;
    alu_src   = 1'b0;
    shift_src = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch_eq = 1'b0;
    branch_ne = 1'b0;
    sign_ext  = 1'b0;
    use_rs    = 1'b0;
    use_rt    = 1'b0;
    dest_rt   = 1'b0;
    if (id_valid) begin
      case (opcode_e'(id_instr[31:26]))
        OP_SPECIAL: begin
          reg_write = 1'b1;
          use_rt    = 1'b1;
          use_rs    = 1'b1;
          case (funct_e'(id_instr[5:0]))
            FN_SLL: begin
              alu_op    = ALU_SLL;
              shift_src = 1'b1;
              use_rs    = 1'b0;
            end
            FN_SRL: begin
              alu_op    = ALU_SRL;
              shift_src = 1'b1;
              use_rs    = 1'b0;
            end
            FN_ADDU: alu_op = ALU_ADD;
            FN_SUBU: alu_op = ALU_SUB;
            FN_AND:  alu_op = ALU_AND;
            FN_OR:   alu_op = ALU_OR;
            FN_XOR:  alu_op = ALU_XOR;
            FN_SLT:  alu_op = ALU_SLT;
            default: begin
              // unknown function acts as a no-op
              reg_write = 1'b0;
              use_rs    = 1'b0;
              use_rt    = 1'b0;
            end
          endcase
        end
        OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
          reg_write = 1'b1;
          alu_src   = 1'b1;
          dest_rt   = 1'b1;
          use_rs    = id_instr[31:26] != OP_LUI;
          sign_ext  = id_instr[31:26] == OP_ADDIU || id_instr[31:26] == OP_LW;
          mem_read  = id_instr[31:26] == OP_LW;
          case (opcode_e'(id_instr[31:26]))
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_LUI:  alu_op = ALU_LUI;
            default: alu_op = ALU_ADD;
          endcase
        end
        OP_SW: begin
          mem_write = 1'b1;
          alu_src   = 1'b1;
          sign_ext  = 1'b1;
          use_rs    = 1'b1;
          use_rt    = 1'b1;
        end
        OP_BEQ, OP_BNE: begin
          branch_eq = id_instr[31:26] == OP_BEQ;
          branch_ne = id_instr[31:26] == OP_BNE;
          use_rs    = 1'b1;
          use_rt    = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // control bits of the decode-to-execute register, bubble on stall or flush
  always_ff @(posedge clk) begin
    if (reset || stall || flush) begin
      ex_alu_src   <= 1'b0;
      ex_shift_src <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_branch_eq <= 1'b0;
      ex_branch_ne <= 1'b0;
    end else begin
      ex_alu_src   <= alu_src;
      ex_shift_src <= shift_src;
      ex_reg_write <= reg_write;
      ex_mem_read  <= mem_read;
      ex_mem_write <= mem_write;
      ex_branch_eq <= branch_eq;
      ex_branch_ne <= branch_ne;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs     <= id_rs;
    ex_rt     <= id_rt;
    ex_rd     <= dest_rt ? rt_f : rd_f;
    ex_a      <= rs_data;
    ex_b      <= rt_data;
    ex_imm    <= sign_ext ? sext_imm : word_t'(imm16);
    ex_target <= id_pc_plus4 + (sext_imm << 2);
    ex_shamt  <= id_instr[10:6];
    ex_alu_op <= alu_op;
  end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module fetch_stage
  import mips_isa_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  input  logic  redirect,
  input  word_t branch_target,
  input  word_t imem_data,
  output word_t imem_addr,
  output word_t id_instr,
  output word_t id_pc_plus4,
  output logic  id_valid
);

  word_t pc;
  word_t pc_plus4;

  assign pc_plus4  = pc + word_t'(4);
  assign imem_addr = pc;

  // redirect wins; the slot fetched alongside it is a wrong-path instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= word_t'(`MIPS_RESET_PC);
      id_valid <= 1'b0;
    end else if (redirect) begin
      pc       <= branch_target;
      id_valid <= 1'b0;
    end else if (!stall) begin
      pc       <= pc_plus4;
      id_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      id_instr    <= imem_data;
      id_pc_plus4 <= pc_plus4;
    end
  end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module reg_file
  import mips_isa_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     write,
  input  reg_idx_t rd,
  input  reg_idx_t rs,
  input  reg_idx_t rt,
  input  word_t    wdata,
  output word_t    rs_data,
  output word_t    rt_data
);

  word_t regs [`MIPS_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rs_data = (rs == '0) ? '0 : (write && rd == rs) ? wdata : regs[rs];
  assign rt_data = (rt == '0) ? '0 : (write && rd == rt) ? wdata : regs[rt];

endmodule

// File: logic/mips_pipe_pkg.sv
package mips_pipe_pkg;

  // alu operation chosen in decode
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7,
    ALU_LUI = 4'd8
  } alu_op_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

endpackage

// File: logic/mips_isa_pkg.sv
`include "mips_cfg.svh"

package mips_isa_pkg;

  typedef logic [`MIPS_XLEN-1:0] word_t;
  typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] reg_idx_t;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_e;

  // function field of OP_SPECIAL, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_e;

endpackage

// File: logic/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data and instruction word width
`define MIPS_XLEN 32

// architectural register count
`define MIPS_REG_COUNT 32

// data memory depth in words, indexed by byte address above bit 1
`define MIPS_DMEM_WORDS 256

// first fetch address
`define MIPS_RESET_PC 0

`endif
